// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_wb_pipe_tail \
	-f wb_pipe_tail.f -o sim_wb_pipe_tail > build.log 2>&1 \
	|| { cat build.log; echo "Build failed, see build.log"; exit 1; }
./obj_dir/sim_wb_pipe_tail > sim.log 2>&1
cat sim.log
grep -q '^\*\*\* PASSED \*\*\*$' sim.log && echo "Simulation passed" \
	|| { echo "Simulation failed, see sim.log"; exit 1; }

// ==== src/lane_align.sv ====
`timescale 1ns/10ps

module lane_align(
	// From data cache
	input wb_pkg::vector_t dcache_data,

	// Address pieces from the memory access stage
	input wb_pkg::lane_idx_t cache_lane_select,
	input logic [1:0] byte_offset,

	// Decoded operation
	input wb_pkg::mem_op_t mem_op,

	// Load data
	output wb_pkg::word_t aligned_value,
	output wb_pkg::vector_t swapped_line
);

	int unsigned lane_base;
	wb_pkg::word_t lane_word;
	logic [7:0] byte_sel;
	logic [15:0] half_sel;

	// Big-endian memory word to little-endian register word
	function automatic wb_pkg::word_t swap_bytes(input wb_pkg::word_t w);
		swap_bytes = {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	// Lane 0 sits in the top bits of the line
	assign lane_base = wb_pkg::LANE_W
		* (wb_pkg::NUM_LANES - 1 - int'(cache_lane_select));
	assign lane_word = dcache_data[lane_base +: wb_pkg::LANE_W];

	// Offset 0 is the most significant byte
	always_comb
	begin
		case (byte_offset)
			2'b00: byte_sel = lane_word[31:24];
			2'b01: byte_sel = lane_word[23:16];
			2'b10: byte_sel = lane_word[15:8];
			default: byte_sel = lane_word[7:0];
		endcase
	end

	// Halfword is stored high byte first
	always_comb
	begin
		if (byte_offset[1])
			half_sel = {lane_word[7:0], lane_word[15:8]};
		else
			half_sel = {lane_word[23:16], lane_word[31:24]};
	end

	// Width and sign handling
	always_comb
	begin
		case (mem_op)
			wb_pkg::MEM_B: aligned_value = {24'b0, byte_sel};
			wb_pkg::MEM_BX: aligned_value = {{24{byte_sel[7]}}, byte_sel};
			wb_pkg::MEM_S: aligned_value = {16'b0, half_sel};
			wb_pkg::MEM_SX: aligned_value = {{16{half_sel[15]}}, half_sel};

			// Word, sync word and the single-lane vector forms
			default: aligned_value = swap_bytes(lane_word);
		endcase
	end

	// Block loads, every lane swapped in place
	always_comb
	begin
		for (int i = 0; i < wb_pkg::NUM_LANES; i++)
			swapped_line[i * wb_pkg::LANE_W +: wb_pkg::LANE_W] =
				swap_bytes(dcache_data[i * wb_pkg::LANE_W +: wb_pkg::LANE_W]);
	end

endmodule

// ==== src/mem_decode.sv ====
`timescale 1ns/10ps

module mem_decode(
	// From memory access stage
	input wb_pkg::word_t instruction,

	// Decoded fields
	output logic is_load,
	output wb_pkg::mem_op_t mem_op,
	output logic is_control_transfer,
	output logic is_sync_store,
	output logic is_nop
);

	logic is_mem_fmt;

	// Memory format is picked by the top two bits
	assign is_mem_fmt = instruction[31:30] == wb_pkg::MEM_FMT;

	// Bit 29 set means load, clear means store
	assign is_load = is_mem_fmt && instruction[29];

	// Operation code, only meaningful in memory format
	assign mem_op = instruction[28:25];

	// Control register transfer shares the load encoding
	// but its result does not come from the cache
	assign is_control_transfer = is_mem_fmt
		&& mem_op == wb_pkg::MEM_CONTROL_REG;

	// Sync store returns a success flag from the cache
	assign is_sync_store = instruction[31:25] == wb_pkg::SYNC_STORE_OP;

	// Bubble, not counted as retired
	assign is_nop = instruction == wb_pkg::NOP_WORD;

endmodule

// ==== src/wb_pipe_tail.sv ====
`timescale 1ns/10ps

module wb_pipe_tail(
	input logic clk,
	input logic reset,

	// From memory access stage
	input wb_pkg::word_t instruction,
	input wb_pkg::word_t pc,
	input wb_pkg::reg_idx_t writeback_reg,
	input logic enable_scalar_writeback,
	input logic enable_vector_writeback,
	input wb_pkg::lane_mask_t mask,
	input logic was_load,
	input logic was_io,
	input wb_pkg::word_t io_response,
	input logic alignment_fault,
	input wb_pkg::vector_t result,
	input wb_pkg::lane_idx_t reg_lane_select,
	input wb_pkg::lane_idx_t cache_lane_select,
	input wb_pkg::strand_t strand,

	// From data cache
	input logic dcache_hit,
	input wb_pkg::vector_t dcache_data,
	input logic dcache_load_collision,
	input logic stbuf_rollback,

	// From control registers
	input wb_pkg::word_t exception_handler_address,

	// To register file
	output logic wb_enable_scalar,
	output logic wb_enable_vector,
	output wb_pkg::reg_idx_t wb_reg,
	output wb_pkg::vector_t wb_value,
	output wb_pkg::lane_mask_t wb_mask,

	// To rollback controller
	output logic rollback_request,
	output wb_pkg::word_t rollback_pc,
	output logic suspend_request,
	output logic retry,

	// To control registers
	output logic latch_fault,
	output wb_pkg::word_t fault_pc,
	output wb_pkg::strand_t fault_strand,

	// Performance event
	output logic instruction_retire
);

	logic is_load;
	wb_pkg::mem_op_t mem_op;
	logic is_control_transfer;
	logic is_sync_store;
	logic is_nop;
	wb_pkg::word_t aligned_value;
	wb_pkg::vector_t swapped_line;

	// Instruction field decode
	mem_decode decode_i(
		.instruction(instruction),
		.is_load(is_load),
		.mem_op(mem_op),
		.is_control_transfer(is_control_transfer),
		.is_sync_store(is_sync_store),
		.is_nop(is_nop)
	);

	// Result still holds the effective address in its low bits
	lane_align align_i(
		.dcache_data(dcache_data),
		.cache_lane_select(cache_lane_select),
		.byte_offset(result[1:0]),
		.mem_op(mem_op),
		.aligned_value(aligned_value),
		.swapped_line(swapped_line)
	);

	// Commit, rollback and register file outputs
	writeback_stage writeback_i(
		.clk(clk),
		.reset(reset),
		.is_load(is_load),
		.mem_op(mem_op),
		.is_control_transfer(is_control_transfer),
		.is_sync_store(is_sync_store),
		.is_nop(is_nop),
		.aligned_value(aligned_value),
		.swapped_line(swapped_line),
		.pc(pc),
		.writeback_reg(writeback_reg),
		.enable_scalar_writeback(enable_scalar_writeback),
		.enable_vector_writeback(enable_vector_writeback),
		.mask(mask),
		.was_load(was_load),
		.was_io(was_io),
		.io_response(io_response),
		.alignment_fault(alignment_fault),
		.result(result),
		.reg_lane_select(reg_lane_select),
		.strand(strand),
		.dcache_hit(dcache_hit),
		.dcache_data(dcache_data),
		.dcache_load_collision(dcache_load_collision),
		.stbuf_rollback(stbuf_rollback),
		.exception_handler_address(exception_handler_address),
		.wb_enable_scalar(wb_enable_scalar),
		.wb_enable_vector(wb_enable_vector),
		.wb_reg(wb_reg),
		.wb_value(wb_value),
		.wb_mask(wb_mask),
		.rollback_request(rollback_request),
		.rollback_pc(rollback_pc),
		.suspend_request(suspend_request),
		.retry(retry),
		.latch_fault(latch_fault),
		.fault_pc(fault_pc),
		.fault_strand(fault_strand),
		.instruction_retire(instruction_retire)
	);

endmodule

// ==== src/wb_pkg.sv ====
package wb_pkg;

	// Lane geometry of the vector unit
	localparam int NUM_LANES = 4;
	localparam int LANE_W = 32;
	localparam int VECTOR_W = NUM_LANES * LANE_W;

	// Register index is {strand, register}
	localparam int REG_IDX_W = 7;
	localparam int STRAND_W = 2;

	// Writing this register means a branch
	localparam int PC_REG = 31;

	// Scalar word
	typedef logic [LANE_W - 1:0] word_t;

	// Full vector, lane 0 in the top bits
	typedef logic [VECTOR_W - 1:0] vector_t;

	// One write enable bit per lane
	typedef logic [NUM_LANES - 1:0] lane_mask_t;

	// Lane number
	typedef logic [$clog2(NUM_LANES) - 1:0] lane_idx_t;

	// Register file index
	typedef logic [REG_IDX_W - 1:0] reg_idx_t;

	// Memory operation code, instruction bits 28:25
	typedef logic [3:0] mem_op_t;

	// Hardware strand number
	typedef logic [STRAND_W - 1:0] strand_t;

	// All-zero word is a NOP and never counts as retired
	localparam word_t NOP_WORD = '0;

	// Top two instruction bits of the memory format
	localparam logic [1:0] MEM_FMT = 2'b10;

	// Scalar forms
	localparam mem_op_t MEM_B = 4'b0000;
	localparam mem_op_t MEM_BX = 4'b0001;
	localparam mem_op_t MEM_S = 4'b0010;
	localparam mem_op_t MEM_SX = 4'b0011;
	localparam mem_op_t MEM_L = 4'b0100;
	localparam mem_op_t MEM_SYNC = 4'b0101;
	localparam mem_op_t MEM_CONTROL_REG = 4'b0110;

	// Block forms, the unmasked one sits below bit 3
	localparam mem_op_t MEM_BLOCK = 4'b0111;
	localparam mem_op_t MEM_BLOCK_M = 4'b1000;
	localparam mem_op_t MEM_BLOCK_IM = 4'b1001;

	// Strided codes run up to the gather base,
	// gather codes from there to the top
	localparam mem_op_t MEM_STRIDED = 4'b1010;
	localparam mem_op_t MEM_SCGATH = 4'b1101;

	// Format, store flag and sync op in instruction bits 31:25
	localparam logic [6:0] SYNC_STORE_OP = {MEM_FMT, 1'b0, MEM_SYNC};

endpackage

// ==== src/writeback_stage.sv ====
`timescale 1ns/10ps

module writeback_stage(
	input logic clk,
	input logic reset,

	// From mem_decode
	input logic is_load,
	input wb_pkg::mem_op_t mem_op,
	input logic is_control_transfer,
	input logic is_sync_store,
	input logic is_nop,

	// From lane_align
	input wb_pkg::word_t aligned_value,
	input wb_pkg::vector_t swapped_line,

	// From memory access stage
	input wb_pkg::word_t pc,
	input wb_pkg::reg_idx_t writeback_reg,
	input logic enable_scalar_writeback,
	input logic enable_vector_writeback,
	input wb_pkg::lane_mask_t mask,
	input logic was_load,
	input logic was_io,
	input wb_pkg::word_t io_response,
	input logic alignment_fault,
	input wb_pkg::vector_t result,
	input wb_pkg::lane_idx_t reg_lane_select,
	input wb_pkg::strand_t strand,

	// From data cache
	input logic dcache_hit,
	input wb_pkg::vector_t dcache_data,
	input logic dcache_load_collision,
	input logic stbuf_rollback,

	// From control registers
	input wb_pkg::word_t exception_handler_address,

	// To register file
	output logic wb_enable_scalar,
	output logic wb_enable_vector,
	output wb_pkg::reg_idx_t wb_reg,
	output wb_pkg::vector_t wb_value,
	output wb_pkg::lane_mask_t wb_mask,

	// To rollback controller
	output logic rollback_request,
	output wb_pkg::word_t rollback_pc,
	output logic suspend_request,
	output logic retry,

	// To control registers
	output logic latch_fault,
	output wb_pkg::word_t fault_pc,
	output wb_pkg::strand_t fault_strand,

	// Performance event
	output logic instruction_retire
);

	logic cache_miss;
	logic pc_load;
	logic is_block;
	logic is_strided;
	logic is_gather;
	wb_pkg::vector_t value_nxt;
	wb_pkg::lane_mask_t mask_nxt;

	// Collision is reported apart from a plain miss
	assign cache_miss = !dcache_hit && was_load && !dcache_load_collision;

	// Scalar load into the PC register of any strand
	assign pc_load = enable_scalar_writeback && is_load
		&& writeback_reg[4:0] == 5'(wb_pkg::PC_REG);

	// Rollback causes, highest priority first
	always_comb
	begin
		rollback_request = 1'b0;
		rollback_pc = '0;
		suspend_request = 1'b0;
		retry = 1'b0;
		if (alignment_fault)
		begin
			// Off to the exception handler
			rollback_request = 1'b1;
			rollback_pc = exception_handler_address;
		end
		else if (was_io)
		begin
			// Device access, cache status means nothing here
		end
		else if (dcache_load_collision)
		begin
			// Line arrived a cycle late, reissue
			rollback_request = 1'b1;
			rollback_pc = pc - 32'd4;
			retry = 1'b1;
		end
		else if (cache_miss || stbuf_rollback)
		begin
			// Strand waits for the fill or the store buffer
			rollback_request = 1'b1;
			rollback_pc = pc - 32'd4;
			suspend_request = 1'b1;
		end
		else if (pc_load)
		begin
			// Checked after a miss, else the branch would use stale data
			rollback_request = 1'b1;
			rollback_pc = aligned_value;
		end
	end

	// Fault details captured with the faulting instruction
	assign latch_fault = alignment_fault;
	assign fault_pc = pc;
	assign fault_strand = strand;

	assign instruction_retire = !rollback_request && !is_nop;

	// Vector form classes
	assign is_block = mem_op inside {wb_pkg::MEM_BLOCK, wb_pkg::MEM_BLOCK_M,
		wb_pkg::MEM_BLOCK_IM};
	assign is_strided = mem_op inside {[wb_pkg::MEM_STRIDED : wb_pkg::MEM_SCGATH - 4'd1]};
	assign is_gather = mem_op >= wb_pkg::MEM_SCGATH;

	// Writeback value source
	always_comb
	begin
		value_nxt = result;
		mask_nxt = mask;
		if (is_sync_store)
		begin
			// Success flag comes back in the line
			value_nxt = dcache_data;
			mask_nxt = '1;
		end
		else if (is_load && !is_control_transfer)
		begin
			if (was_io)
			begin
				value_nxt = {wb_pkg::NUM_LANES{io_response}};
				mask_nxt = '1;
			end
			else if (is_block)
			begin
				value_nxt = swapped_line;
			end
			else if (is_strided || is_gather)
			begin
				// One lane per cycle, lane numbers count up from the mask LSB
				value_nxt = {wb_pkg::NUM_LANES{aligned_value}};
				mask_nxt = wb_pkg::lane_mask_t'(1 << reg_lane_select) & mask;
			end
			else
			begin
				// Scalar load
				value_nxt = {wb_pkg::NUM_LANES{aligned_value}};
				mask_nxt = '1;
			end
		end
	end

	// Register file write port, one cycle behind
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			wb_enable_scalar <= 1'b0;
			wb_enable_vector <= 1'b0;
			wb_reg <= '0;
			wb_value <= '0;
			wb_mask <= '0;
		end
		else
		begin
			// Rolled back instructions never commit
			wb_enable_scalar <= enable_scalar_writeback && !rollback_request;
			wb_enable_vector <= enable_vector_writeback && !rollback_request;
			wb_reg <= writeback_reg;
			wb_value <= value_nxt;
			wb_mask <= mask_nxt;
		end
	end

endmodule

// ==== test/tb_wb_pipe_tail.sv ====
`timescale 1ns/10ps

module tb_wb_pipe_tail;

	logic clk = 1'b0;
	logic reset;
	wb_pkg::word_t instruction;
	wb_pkg::word_t pc;
	wb_pkg::reg_idx_t writeback_reg;
	logic enable_scalar_writeback;
	logic enable_vector_writeback;
	wb_pkg::lane_mask_t mask;
	logic was_load;
	logic was_io;
	wb_pkg::word_t io_response;
	logic alignment_fault;
	wb_pkg::vector_t result;
	wb_pkg::lane_idx_t reg_lane_select;
	wb_pkg::lane_idx_t cache_lane_select;
	wb_pkg::strand_t strand;
	logic dcache_hit;
	wb_pkg::vector_t dcache_data;
	logic dcache_load_collision;
	logic stbuf_rollback;
	wb_pkg::word_t exception_handler_address;
	logic wb_enable_scalar;
	logic wb_enable_vector;
	wb_pkg::reg_idx_t wb_reg;
	wb_pkg::vector_t wb_value;
	wb_pkg::lane_mask_t wb_mask;
	logic rollback_request;
	wb_pkg::word_t rollback_pc;
	logic suspend_request;
	logic retry;
	logic latch_fault;
	wb_pkg::word_t fault_pc;
	wb_pkg::strand_t fault_strand;
	logic instruction_retire;

	// Cache line model, lane 0 first
	wb_pkg::word_t line_words[wb_pkg::NUM_LANES];
	integer seed;
	int checks;
	int errors;
	int test_checks;
	int test_errors;
	int tests_run;

	wb_pipe_tail dut_i(.*);

	// 100 ns period
	always #50 clk = ~clk;

	// Reset held for two full cycles, released on a falling edge
	initial
	begin
		reset = 1'b1;
		repeat (2) @(negedge clk);
		reset = 1'b0;
	end

	// Byte at a memory offset, offset 0 is the top byte of the lane
	function automatic logic [7:0] mem_byte(int lane, int off);
		return line_words[lane][31 - 8 * off -: 8];
	endfunction

	function automatic wb_pkg::vector_t line_vec();
		return {line_words[0], line_words[1], line_words[2], line_words[3]};
	endfunction

	// Register word, lowest address lands in the low byte
	function automatic wb_pkg::word_t mem_word(int lane);
		return {mem_byte(lane, 3), mem_byte(lane, 2), mem_byte(lane, 1), mem_byte(lane, 0)};
	endfunction

	// Expected scalar load value for one op, lane and offset
	function automatic wb_pkg::word_t load_expect(wb_pkg::mem_op_t op, int lane, int off);
		logic [7:0] b;
		logic [15:0] h;
		b = mem_byte(lane, off);
		h = {mem_byte(lane, (off & 2) + 1), mem_byte(lane, off & 2)};
		case (op)
			wb_pkg::MEM_B: return {24'b0, b};
			wb_pkg::MEM_BX: return {{24{b[7]}}, b};
			wb_pkg::MEM_S: return {16'b0, h};
			wb_pkg::MEM_SX: return {{16{h[15]}}, h};
			default: return mem_word(lane);
		endcase
	endfunction

	// Memory format word with load flag and op code
	function automatic wb_pkg::word_t mem_instr(logic load, wb_pkg::mem_op_t op);
		return {wb_pkg::MEM_FMT, load, op, 25'h00000a5};
	endfunction

	// Neutral values on every DUT input
	task set_idle;
		instruction = '0;
		pc = 32'h0000_1000;
		writeback_reg = 7'h05;
		enable_scalar_writeback = 1'b0;
		enable_vector_writeback = 1'b0;
		mask = '0;
		was_load = 1'b0;
		was_io = 1'b0;
		io_response = '0;
		alignment_fault = 1'b0;
		result = '0;
		reg_lane_select = '0;
		cache_lane_select = '0;
		strand = '0;
		dcache_hit = 1'b1;
		dcache_data = line_vec();
		dcache_load_collision = 1'b0;
		stbuf_rollback = 1'b0;
		exception_handler_address = 32'h8000_0100;
	endtask

	task expect_value(string what, logic [127:0] got, logic [127:0] exp);
		checks++;
		test_checks++;
		assert (got === exp)
		else
		begin
			$display("Error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
			errors++;
			test_errors++;
		end
	endtask

	task check_rollback(logic exp_rb, wb_pkg::word_t exp_pc, logic exp_suspend, logic exp_retry);
		expect_value("rollback_request", 128'(rollback_request), 128'(exp_rb));
		expect_value("rollback_pc", 128'(rollback_pc), 128'(exp_pc));
		expect_value("suspend_request", 128'(suspend_request), 128'(exp_suspend));
		expect_value("retry", 128'(retry), 128'(exp_retry));
	endtask

	// Registered outputs are sampled just after the edge
	task step_clock;
		@(posedge clk);
		#1;
	endtask

	task finish_test(string name);
		$display("%s: %0d checks, %0d errors", name, test_checks, test_errors);
		tests_run++;
		test_checks = 0;
		test_errors = 0;
	endtask

	// Hitting scalar load on the falling edge
	task start_load(wb_pkg::mem_op_t op, int lane, int off);
		@(negedge clk);
		set_idle;
		instruction = mem_instr(1'b1, op);
		was_load = 1'b1;
		enable_scalar_writeback = 1'b1;
		cache_lane_select = 2'(lane);
		result = {96'b0, 30'h400, 2'(off)};
		mask = 4'b0110;
	endtask

	task reset_and_passthrough(output bit released);
		int cycles;
		wb_pkg::vector_t exp_value;
		// Enables and mask held high while reset is asserted
		enable_scalar_writeback = 1'b1;
		enable_vector_writeback = 1'b1;
		mask = 4'hf;
		@(negedge clk);
		#1;
		expect_value("wb_enable_scalar in reset", 128'(wb_enable_scalar), 128'(0));
		expect_value("wb_enable_vector in reset", 128'(wb_enable_vector), 128'(0));
		expect_value("wb_mask in reset", 128'(wb_mask), 128'(0));
		cycles = 0;
		while (reset && cycles < 10)
		begin
			@(negedge clk);
			#1;
			cycles++;
		end
		released = !reset;
		if (released)
		begin
			expect_value("wb_enable_scalar after reset", 128'(wb_enable_scalar), 128'(0));
			expect_value("wb_enable_vector after reset", 128'(wb_enable_vector), 128'(0));
			expect_value("wb_mask after reset", 128'(wb_mask), 128'(0));
			// All-zero instruction is a bubble
			expect_value("instruction_retire on nop", 128'(instruction_retire), 128'(0));
			// Top bits 00, not a memory instruction
			@(negedge clk);
			set_idle;
			instruction = 32'h0400_1234;
			result = {$random(seed), $random(seed), $random(seed), $random(seed)};
			exp_value = result;
			mask = 4'b0101;
			enable_vector_writeback = 1'b1;
			writeback_reg = 7'h23;
			#1;
			check_rollback(1'b0, '0, 1'b0, 1'b0);
			expect_value("instruction_retire", 128'(instruction_retire), 128'(1));
			step_clock;
			expect_value("wb_enable_vector", 128'(wb_enable_vector), 128'(1));
			expect_value("wb_enable_scalar", 128'(wb_enable_scalar), 128'(0));
			expect_value("wb_reg", 128'(wb_reg), 128'(7'h23));
			expect_value("wb_value", wb_value, exp_value);
			expect_value("wb_mask", 128'(wb_mask), 128'(4'b0101));
			finish_test("reset_and_passthrough");
		end
	endtask

	task scalar_loads;
		wb_pkg::mem_op_t ops[5];
		wb_pkg::word_t exp_word;
		ops = '{wb_pkg::MEM_B, wb_pkg::MEM_BX, wb_pkg::MEM_S, wb_pkg::MEM_SX, wb_pkg::MEM_L};
		for (int lane = 0; lane < wb_pkg::NUM_LANES; lane++)
			for (int off = 0; off < 4; off++)
				for (int k = 0; k < 5; k++)
				begin
					start_load(ops[k], lane, off);
					exp_word = load_expect(ops[k], lane, off);
					#1;
					expect_value("rollback_request", 128'(rollback_request), 128'(0));
					step_clock;
					expect_value($sformatf("op %0h lane %0d offset %0d value", ops[k], lane, off),
						wb_value, {4{exp_word}});
					expect_value("wb_mask", 128'(wb_mask), 128'(4'hf));
					expect_value("wb_enable_scalar", 128'(wb_enable_scalar), 128'(1));
				end
		finish_test("scalar_loads");
	endtask

	task vector_loads;
		wb_pkg::word_t io_word;
		// Masked block load, each lane swapped in place
		start_load(wb_pkg::MEM_BLOCK_M, 0, 0);
		enable_scalar_writeback = 1'b0;
		enable_vector_writeback = 1'b1;
		mask = 4'b1011;
		step_clock;
		expect_value("block value", wb_value, {mem_word(0), mem_word(1), mem_word(2), mem_word(3)});
		expect_value("block mask", 128'(wb_mask), 128'(4'b1011));
		expect_value("block enable", 128'(wb_enable_vector), 128'(1));
		// Strided, one register lane per cycle
		for (int sel = 0; sel < wb_pkg::NUM_LANES; sel++)
		begin
			start_load(wb_pkg::MEM_STRIDED, 2, 0);
			enable_scalar_writeback = 1'b0;
			enable_vector_writeback = 1'b1;
			reg_lane_select = 2'(sel);
			mask = 4'b1110;
			step_clock;
			expect_value("strided value", wb_value, {4{mem_word(2)}});
			expect_value($sformatf("strided mask lane %0d", sel), 128'(wb_mask),
				128'(4'b1110 & (4'b0001 << sel)));
		end
		// Sync store hands back the raw line
		@(negedge clk);
		set_idle;
		instruction = mem_instr(1'b0, wb_pkg::MEM_SYNC);
		enable_vector_writeback = 1'b1;
		mask = 4'b0001;
		step_clock;
		expect_value("sync store value", wb_value, line_vec());
		expect_value("sync store mask", 128'(wb_mask), 128'(4'hf));
		// I/O load ignores the missing cache
		start_load(wb_pkg::MEM_L, 1, 0);
		was_io = 1'b1;
		dcache_hit = 1'b0;
		io_response = $random(seed);
		io_word = io_response;
		#1;
		expect_value("io rollback_request", 128'(rollback_request), 128'(0));
		step_clock;
		expect_value("io value", wb_value, {4{io_word}});
		expect_value("io mask", 128'(wb_mask), 128'(4'hf));
		finish_test("vector_loads");
	endtask

	task rollback_priority;
		// Fault wins over a miss
		start_load(wb_pkg::MEM_L, 0, 0);
		dcache_hit = 1'b0;
		alignment_fault = 1'b1;
		pc = 32'h0000_2468;
		strand = 2'd2;
		#1;
		check_rollback(1'b1, 32'h8000_0100, 1'b0, 1'b0);
		expect_value("latch_fault", 128'(latch_fault), 128'(1));
		expect_value("fault_pc", 128'(fault_pc), 128'(32'h0000_2468));
		expect_value("fault_strand", 128'(fault_strand), 128'(2'd2));
		expect_value("instruction_retire", 128'(instruction_retire), 128'(0));
		step_clock;
		expect_value("enable after fault", 128'(wb_enable_scalar), 128'(0));
		// Collision means retry
		start_load(wb_pkg::MEM_L, 0, 0);
		dcache_hit = 1'b0;
		dcache_load_collision = 1'b1;
		#1;
		check_rollback(1'b1, 32'h0000_0ffc, 1'b0, 1'b1);
		expect_value("latch_fault on collision", 128'(latch_fault), 128'(0));
		step_clock;
		expect_value("enable after collision", 128'(wb_enable_scalar), 128'(0));
		// Plain miss suspends
		start_load(wb_pkg::MEM_L, 0, 0);
		dcache_hit = 1'b0;
		#1;
		check_rollback(1'b1, 32'h0000_0ffc, 1'b1, 1'b0);
		// Store buffer rollback on a hit
		start_load(wb_pkg::MEM_L, 0, 0);
		stbuf_rollback = 1'b1;
		#1;
		check_rollback(1'b1, 32'h0000_0ffc, 1'b1, 1'b0);
		// Device access with a miss still commits
		start_load(wb_pkg::MEM_L, 0, 0);
		was_io = 1'b1;
		dcache_hit = 1'b0;
		#1;
		check_rollback(1'b0, '0, 1'b0, 1'b0);
		expect_value("io retire", 128'(instruction_retire), 128'(1));
		step_clock;
		expect_value("enable after io", 128'(wb_enable_scalar), 128'(1));
		finish_test("rollback_priority");
	endtask

	task pc_load_branch;
		// Strand 1 loads its PC, branch to the loaded word
		start_load(wb_pkg::MEM_L, 1, 0);
		writeback_reg = {2'b01, 5'd31};
		#1;
		check_rollback(1'b1, mem_word(1), 1'b0, 1'b0);
		step_clock;
		expect_value("enable after pc load", 128'(wb_enable_scalar), 128'(0));
		// Miss takes priority over the branch
		start_load(wb_pkg::MEM_L, 1, 0);
		writeback_reg = {2'b01, 5'd31};
		dcache_hit = 1'b0;
		#1;
		check_rollback(1'b1, 32'h0000_0ffc, 1'b1, 1'b0);
		finish_test("pc_load_branch");
	endtask

	initial
	begin
		bit released;
		seed = 32'h9b6a;
		checks = 0;
		errors = 0;
		test_checks = 0;
		test_errors = 0;
		tests_run = 0;
		// Sign bits set in chosen bytes, random words in lanes 2 and 3
		line_words[0] = 32'h80ff_7f01;
		line_words[1] = 32'h01fe_8000;
		line_words[2] = $random(seed);
		line_words[3] = $random(seed);
		set_idle;
		reset_and_passthrough(released);
		if (!released)
		begin
			$display("Timeout: reset still high after 10 clock cycles");
			$display("*** FAILED ***");
			$finish;
		end
		else
		begin
			scalar_loads;
			vector_loads;
			rollback_priority;
			pc_load_branch;
			$display("Tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
			if (errors == 0)
				$display("*** PASSED ***");
			else
				$display("*** FAILED ***");
			$finish;
		end
	end

endmodule

// ==== wb_pipe_tail.f ====
src/wb_pkg.sv
src/mem_decode.sv
src/lane_align.sv
src/writeback_stage.sv
src/wb_pipe_tail.sv
test/tb_wb_pipe_tail.sv
